/* rtl/core_pkg.sv */
/*
 * core-wide data widths shared by the execution units
 */
`default_nettype none

package core_pkg;

	// machine word width of the RV64 core
	localparam int XLEN = 64;

	// one machine word, used for operands, CSR contents and results
	typedef logic [XLEN-1:0] xlen_t;

	// CSR address field of the SYSTEM instruction encoding
	typedef logic [11:0] csr_addr_t;

endpackage

`default_nettype wire

/* rtl/csr_pkg.sv */
/*
 * CSR map of the machine-mode registers with their write masks and constants,
 * plus the read-modify-write rule that both register banks apply
 */
`default_nettype none

package csr_pkg;

	// machine trap setup
	localparam core_pkg::csr_addr_t CSR_MSTATUS   = 12'h300;
	localparam core_pkg::csr_addr_t CSR_MISA      = 12'h301;
	localparam core_pkg::csr_addr_t CSR_MIE       = 12'h304;
	localparam core_pkg::csr_addr_t CSR_MTVEC     = 12'h305;
	// machine trap handling
	localparam core_pkg::csr_addr_t CSR_MSCRATCH  = 12'h340;
	localparam core_pkg::csr_addr_t CSR_MEPC      = 12'h341;
	localparam core_pkg::csr_addr_t CSR_MCAUSE    = 12'h342;
	localparam core_pkg::csr_addr_t CSR_MTVAL     = 12'h343;
	localparam core_pkg::csr_addr_t CSR_MIP       = 12'h344;
	// machine counters
	localparam core_pkg::csr_addr_t CSR_MCYCLE    = 12'hB00;
	localparam core_pkg::csr_addr_t CSR_MINSTRET  = 12'hB02;
	// machine information, all in the read-only F1x block
	localparam core_pkg::csr_addr_t CSR_MVENDORID = 12'hF11;
	localparam core_pkg::csr_addr_t CSR_MARCHID   = 12'hF12;
	localparam core_pkg::csr_addr_t CSR_MIMPID    = 12'hF13;
	localparam core_pkg::csr_addr_t CSR_MHARTID   = 12'hF14;

	// mstatus keeps only MIE (3), MPIE (7) and MPP (12:11)
	localparam core_pkg::xlen_t MSTATUS_WMASK = 64'h0000_0000_0000_1888;
	// software, timer and external interrupt bits of machine mode
	localparam core_pkg::xlen_t MIE_WMASK     = 64'h0000_0000_0000_0888;
	localparam core_pkg::xlen_t MIP_WMASK     = 64'h0000_0000_0000_0888;
	// exception PC is 2-byte aligned so bit 0 stays clear
	localparam core_pkg::xlen_t MEPC_WMASK    = 64'hFFFF_FFFF_FFFF_FFFE;
	// mode bit 1 is stuck at zero, which leaves direct and vectored only
	localparam core_pkg::xlen_t MTVEC_WMASK   = 64'hFFFF_FFFF_FFFF_FFFD;
	// mscratch, mcause, mtval and the counters take every bit
	localparam core_pkg::xlen_t FULL_WMASK    = 64'hFFFF_FFFF_FFFF_FFFF;

	// value of every writable CSR after reset
	localparam core_pkg::xlen_t CSR_RESET_VALUE = 64'h0;

	// non-commercial implementation reports zero vendor, arch and impl IDs
	localparam core_pkg::xlen_t MVENDORID_VALUE = 64'h0;
	localparam core_pkg::xlen_t MARCHID_VALUE   = 64'h0;
	localparam core_pkg::xlen_t MIMPID_VALUE    = 64'h0;
	// MXL of 2 selects RV64, then the I (bit 8) and M (bit 12) extensions
	localparam core_pkg::xlen_t MISA_VALUE      = 64'h8000_0000_0000_1100;

	// rs and rc with a zero operand only read the register
	function automatic logic csr_wants_write(input logic rw, input logic rs,
			input logic rc, input core_pkg::xlen_t op);
		return rw | ((rs | rc) & (op != '0));
	endfunction

	// new register value before any write mask is applied
	function automatic core_pkg::xlen_t csr_rmw(input logic rw, input logic rs,
			input logic rc, input core_pkg::xlen_t old_val, input core_pkg::xlen_t op);
		if (rw) begin
			return op;
		end else if (rs) begin
			return old_val | op;
		end else if (rc) begin
			return old_val & ~op;
		end
		return old_val;
	endfunction

endpackage

`default_nettype wire

/* rtl/csr_trap_regs.sv */
/*
 * machine trap setup and trap handling CSR bank
 * reads the old value and applies a masked read-modify-write to the addressed register
 */
`timescale 1ns/1ns
`default_nettype none

module csr_trap_regs (
	input  wire                   CLK,
	input  wire                   rst_n,
	input  wire                   exe_valid,
	input  wire                   exe_rw,
	input  wire                   exe_rs,
	input  wire                   exe_rc,
	input  core_pkg::xlen_t       exe_op,
	input  core_pkg::csr_addr_t   exe_addr,
	output logic                  trap_hit,
	output core_pkg::xlen_t       trap_rdata
);

	import core_pkg::*;
	import csr_pkg::*;

	// slot of each register inside the bank
	localparam int NREG         = 8;
	localparam int IDX_MSTATUS  = 0;
	localparam int IDX_MIE      = 1;
	localparam int IDX_MTVEC    = 2;
	localparam int IDX_MSCRATCH = 3;
	localparam int IDX_MEPC     = 4;
	localparam int IDX_MCAUSE   = 5;
	localparam int IDX_MTVAL    = 6;
	localparam int IDX_MIP      = 7;

	xlen_t       regs [NREG];
	logic [2:0]  sel;
	xlen_t       wmask;
	xlen_t       old_val;
	xlen_t       rmw_val;
	xlen_t       new_val;
	logic        do_write;

	// address decode picks the slot and the write mask of that register
	always_comb begin
		trap_hit = 1'b1;
		sel      = 3'd0;
		wmask    = '0;
		case (exe_addr)
			CSR_MSTATUS: begin
				sel   = 3'(IDX_MSTATUS);
				wmask = MSTATUS_WMASK;
			end
			CSR_MIE: begin
				sel   = 3'(IDX_MIE);
				wmask = MIE_WMASK;
			end
			CSR_MTVEC: begin
				sel   = 3'(IDX_MTVEC);
				wmask = MTVEC_WMASK;
			end
			CSR_MSCRATCH: begin
				sel   = 3'(IDX_MSCRATCH);
				wmask = FULL_WMASK;
			end
			CSR_MEPC: begin
				sel   = 3'(IDX_MEPC);
				wmask = MEPC_WMASK;
			end
			CSR_MCAUSE: begin
				sel   = 3'(IDX_MCAUSE);
				wmask = FULL_WMASK;
			end
			CSR_MTVAL: begin
				sel   = 3'(IDX_MTVAL);
				wmask = FULL_WMASK;
			end
			CSR_MIP: begin
				sel   = 3'(IDX_MIP);
				wmask = MIP_WMASK;
			end
			default: begin
				trap_hit = 1'b0;
			end
		endcase
	end

	// old value goes out unchanged, and the bank stays silent on a miss
	assign old_val    = regs[sel];
	assign trap_rdata = trap_hit ? old_val : '0;

	// bits outside the mask keep what the register already holds
	assign rmw_val = csr_rmw(exe_rw, exe_rs, exe_rc, old_val, exe_op);
	assign new_val = (old_val & ~wmask) | (rmw_val & wmask);

	assign do_write = exe_valid & trap_hit & csr_wants_write(exe_rw, exe_rs, exe_rc, exe_op);

	// only the addressed slot changes, on the same edge that registers the result
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NREG; i++) begin
				regs[i] <= CSR_RESET_VALUE;
			end
		end else if (do_write) begin
			regs[sel] <= new_val;
		end
	end

endmodule

`default_nettype wire

/* rtl/csr_counter_regs.sv */
/*
 * machine counter and machine information CSR bank
 * mcycle runs freely, minstret follows retire, the ID registers answer from constants
 */
`timescale 1ns/1ns
`default_nettype none

module csr_counter_regs #(
	parameter core_pkg::xlen_t HART_ID = '0
) (
	input  wire                   CLK,
	input  wire                   rst_n,
	input  wire                   exe_valid,
	input  wire                   exe_rw,
	input  wire                   exe_rs,
	input  wire                   exe_rc,
	input  wire                   retire,
	input  core_pkg::xlen_t       exe_op,
	input  core_pkg::csr_addr_t   exe_addr,
	output logic                  cnt_hit,
	output logic                  cnt_ro_write,
	output core_pkg::xlen_t       cnt_rdata
);

	import core_pkg::*;
	import csr_pkg::*;

	xlen_t  mcycle;
	xlen_t  minstret;
	logic   mcycle_sel;
	logic   minstret_sel;
	logic   ro_addr;
	logic   write_req;
	xlen_t  old_val;
	xlen_t  new_val;

	// read mux, which also leaves old_val at zero when no register matches
	always_comb begin
		cnt_hit      = 1'b1;
		mcycle_sel   = 1'b0;
		minstret_sel = 1'b0;
		old_val      = '0;
		case (exe_addr)
			CSR_MCYCLE: begin
				mcycle_sel = 1'b1;
				old_val    = mcycle;
			end
			CSR_MINSTRET: begin
				minstret_sel = 1'b1;
				old_val      = minstret;
			end
			CSR_MVENDORID: old_val = MVENDORID_VALUE;
			CSR_MARCHID:   old_val = MARCHID_VALUE;
			CSR_MIMPID:    old_val = MIMPID_VALUE;
			CSR_MHARTID:   old_val = HART_ID;
			// misa is legal to write but the write is dropped
			CSR_MISA:      old_val = MISA_VALUE;
			default:       cnt_hit = 1'b0;
		endcase
	end

	assign cnt_rdata = old_val;

	// the top two address bits both set mark the read-only CSR block
	assign ro_addr      = &exe_addr[11:10];
	assign write_req    = exe_valid & cnt_hit & csr_wants_write(exe_rw, exe_rs, exe_rc, exe_op);
	assign cnt_ro_write = write_req & ro_addr;

	// counters take every bit of the operand
	assign new_val = csr_rmw(exe_rw, exe_rs, exe_rc, old_val, exe_op);

	// a software write replaces the increment for that edge
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			mcycle <= CSR_RESET_VALUE;
		end else if (write_req & mcycle_sel) begin
			mcycle <= new_val;
		end else begin
			mcycle <= mcycle + 1'b1;
		end
	end

	// write beats a retire pulse that lands on the same edge
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			minstret <= CSR_RESET_VALUE;
		end else if (write_req & minstret_sel) begin
			minstret <= new_val;
		end else if (retire) begin
			minstret <= minstret + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* rtl/csr_writeback.sv */
/*
 * CSR writeback stage that merges both bank answers, flags illegal
 * accesses and registers the result one cycle after the request
 */
`timescale 1ns/1ns
`default_nettype none

module csr_writeback #(
	parameter int RNBIT = 2
) (
	input  wire                   CLK,
	input  wire                   rst_n,
	input  wire                   exe_valid,
	input  wire                   exe_rw,
	input  wire [5+RNBIT-1:0]     exe_rd0,
	input  wire                   trap_hit,
	input  wire                   cnt_hit,
	input  wire                   cnt_ro_write,
	input  core_pkg::xlen_t       trap_rdata,
	input  core_pkg::xlen_t       cnt_rdata,
	output logic                  wb_valid,
	output core_pkg::xlen_t       wb_res,
	output logic [5+RNBIT-1:0]    wb_rd0,
	output logic                  wb_illegal
);

	import core_pkg::*;

	logic   any_hit;
	logic   illegal;
	logic   dont_read;
	xlen_t  rdata;
	xlen_t  res;

	// a bank that misses drives zero, so an OR is enough to merge them
	assign any_hit = trap_hit | cnt_hit;
	assign rdata   = trap_rdata | cnt_rdata;

	// unknown address or a write into the read-only block
	assign illegal = ~any_hit | cnt_ro_write;

	// csrrw to x0 is a pure write and returns nothing
	assign dont_read = exe_rw & (exe_rd0 == '0);
	assign res       = (illegal | dont_read) ? '0 : rdata;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid   <= 1'b0;
			wb_illegal <= 1'b0;
		end else begin
			wb_valid   <= exe_valid;
			wb_illegal <= exe_valid & illegal;
		end
	end

	// result and tag only mean something while wb_valid is high
	always_ff @(posedge CLK) begin
		wb_res <= res;
		wb_rd0 <= exe_rd0;
	end

endmodule

`default_nettype wire

/* rtl/csr_exec.sv */
/*
 * CSR execution unit of the RV64 core
 * trap bank and counter bank answer in parallel, writeback returns the old value
 */
`timescale 1ns/1ns
`default_nettype none

module csr_exec #(
	parameter int              RNBIT   = 2,
	parameter core_pkg::xlen_t HART_ID = '0
) (
	input  wire                   CLK,
	input  wire                   rst_n,
	input  wire                   exe_valid,
	input  wire                   exe_rw,
	input  wire                   exe_rs,
	input  wire                   exe_rc,
	input  wire [5+RNBIT-1:0]     exe_rd0,
	input  core_pkg::xlen_t       exe_op,
	input  core_pkg::csr_addr_t   exe_addr,
	input  wire                   retire,
	output logic                  wb_valid,
	output core_pkg::xlen_t       wb_res,
	output logic [5+RNBIT-1:0]    wb_rd0,
	output logic                  wb_illegal
);

	import core_pkg::*;

	// answers of the two banks toward writeback
	logic   trap_hit;
	xlen_t  trap_rdata;
	logic   cnt_hit;
	logic   cnt_ro_write;
	xlen_t  cnt_rdata;

	// mstatus, mie, mtvec, mscratch, mepc, mcause, mtval and mip
	csr_trap_regs u_trap_regs (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.exe_valid  (exe_valid),
		.exe_rw     (exe_rw),
		.exe_rs     (exe_rs),
		.exe_rc     (exe_rc),
		.exe_op     (exe_op),
		.exe_addr   (exe_addr),
		.trap_hit   (trap_hit),
		.trap_rdata (trap_rdata)
	);

	// mcycle, minstret, the ID registers and misa
	csr_counter_regs #(
		.HART_ID (HART_ID)
	) u_counter_regs (
		.CLK          (CLK),
		.rst_n        (rst_n),
		.exe_valid    (exe_valid),
		.exe_rw       (exe_rw),
		.exe_rs       (exe_rs),
		.exe_rc       (exe_rc),
		.retire       (retire),
		.exe_op       (exe_op),
		.exe_addr     (exe_addr),
		.cnt_hit      (cnt_hit),
		.cnt_ro_write (cnt_ro_write),
		.cnt_rdata    (cnt_rdata)
	);

	csr_writeback #(
		.RNBIT (RNBIT)
	) u_writeback (
		.CLK          (CLK),
		.rst_n        (rst_n),
		.exe_valid    (exe_valid),
		.exe_rw       (exe_rw),
		.exe_rd0      (exe_rd0),
		.trap_hit     (trap_hit),
		.cnt_hit      (cnt_hit),
		.cnt_ro_write (cnt_ro_write),
		.trap_rdata   (trap_rdata),
		.cnt_rdata    (cnt_rdata),
		.wb_valid     (wb_valid),
		.wb_res       (wb_res),
		.wb_rd0       (wb_rd0),
		.wb_illegal   (wb_illegal)
	);

endmodule

`default_nettype wire

/* testbench/csr_exec_assertions.sv */
/*
 * concurrent assertions on the CSR writeback stage
 */
`timescale 1ns/1ns
`default_nettype none

module csr_exec_assertions (
	input  wire                   CLK,
	input  wire                   rst_n,
	input  wire                   exe_valid,
	input  wire                   wb_valid,
	input  wire                   wb_illegal,
	input  core_pkg::xlen_t       wb_res
);

	// number of assertion failures, read by the testbench at the end of the run
	int fail_count = 0;

	// a result leaves writeback exactly one cycle after its request
	valid_follows: assert property (@(posedge CLK) disable iff (!rst_n)
			wb_valid == $past(exe_valid))
		else begin
			$error("wb_valid does not follow exe_valid by one cycle");
			fail_count++;
		end

	illegal_needs_valid: assert property (@(posedge CLK) disable iff (!rst_n)
			wb_illegal |-> wb_valid)
		else begin
			$error("wb_illegal is high while wb_valid is low");
			fail_count++;
		end

	// an illegal access never leaks CSR contents to the register file
	illegal_zero_res: assert property (@(posedge CLK) disable iff (!rst_n)
			wb_illegal |-> (wb_res == '0))
		else begin
			$error("wb_res is not zero on an illegal access");
			fail_count++;
		end

endmodule

bind csr_writeback csr_exec_assertions u_assert (
	.CLK        (CLK),
	.rst_n      (rst_n),
	.exe_valid  (exe_valid),
	.wb_valid   (wb_valid),
	.wb_illegal (wb_illegal),
	.wb_res     (wb_res)
);

`default_nettype wire

/* testbench/csr_checker.sv */
/*
 * result checker of the CSR execution unit
 * pairs each writeback with the oldest expected row and compares the values
 */
`timescale 1ns/1ns
`default_nettype none

module csr_checker #(
	parameter int RNBIT = 2
) (
	input  wire                   CLK,
	input  wire                   rst_n,
	input  wire                   wb_valid,
	input  core_pkg::xlen_t       wb_res,
	input  wire [5+RNBIT-1:0]     wb_rd0,
	input  wire                   wb_illegal
);

	import core_pkg::*;

	int errors  = 0;
	int checked = 0;
	int passed  = 0;

	// expected results of requests in flight, oldest first
	int                 id_q  [$];
	xlen_t              res_q [$];
	logic [5+RNBIT-1:0] rd0_q [$];
	logic               ill_q [$];

	task automatic push_expected(input int id, input xlen_t res,
			input logic [5+RNBIT-1:0] rd0, input logic ill);
		id_q.push_back(id);
		res_q.push_back(res);
		rd0_q.push_back(rd0);
		ill_q.push_back(ill);
	endtask

	// gives the last results a bounded number of cycles to come back
	task automatic wait_drained(input int max_cycles, output bit ok);
		int n;
		n = 0;
		while (id_q.size() != 0 && n < max_cycles) begin
			@(posedge CLK);
			n++;
		end
		ok = (id_q.size() == 0);
		if (!ok) begin
			$display("timed out waiting for wb_valid, %0d results never came", id_q.size());
		end
	endtask

	// outputs move at the rising edge, so the falling edge sees them settled
	always @(negedge CLK) begin : compare
		int                 id;
		xlen_t              e_res;
		logic [5+RNBIT-1:0] e_rd0;
		logic               e_ill;
		logic               bad;
		if (rst_n && wb_valid) begin
			if (id_q.size() == 0) begin
				$display("wb_valid came with no request pending");
				errors++;
			end else begin
				id    = id_q.pop_front();
				e_res = res_q.pop_front();
				e_rd0 = rd0_q.pop_front();
				e_ill = ill_q.pop_front();
				bad   = 1'b0;
				if (wb_res !== e_res) begin
					$display("error test %0d wb_res: got 0x%h, expected 0x%h", id, wb_res, e_res);
					bad = 1'b1;
				end
				if (wb_illegal !== e_ill) begin
					$display("error test %0d wb_illegal: got 0x%h, expected 0x%h", id,
						wb_illegal, e_ill);
					bad = 1'b1;
				end
				if (wb_rd0 !== e_rd0) begin
					$display("error test %0d wb_rd0: got 0x%h, expected 0x%h", id, wb_rd0, e_rd0);
					bad = 1'b1;
				end
				checked++;
				if (bad) begin
					errors++;
				end else begin
					passed++;
					$display("test %0d ok", id);
				end
			end
		end
	end

endmodule

`default_nettype wire

/* testbench/tb_csr_exec.sv */
/*
 * testbench of the CSR execution unit
 * builds a table of CSR accesses with expected results and applies one row per cycle
 */
`timescale 1ns/1ns
`default_nettype none

module tb_csr_exec;

	import core_pkg::*;
	import csr_pkg::*;

	localparam int RNBIT    = 2;
	localparam int MAX_ROWS = 64;
	localparam xlen_t HART  = 64'd5;
	// access kinds of a table row
	localparam int RW = 0;
	localparam int RS = 1;
	localparam int RC = 2;

	typedef logic [RNBIT+4:0] tag_t;

	logic       CLK;
	logic       rst_n;
	logic       exe_valid;
	logic       exe_rw;
	logic       exe_rs;
	logic       exe_rc;
	logic       retire;
	tag_t       exe_rd0;
	xlen_t      exe_op;
	csr_addr_t  exe_addr;
	logic       wb_valid;
	logic       wb_illegal;
	xlen_t      wb_res;
	tag_t       wb_rd0;

	// stimulus table, one entry per cycle
	logic       t_valid  [MAX_ROWS];
	int         t_kind   [MAX_ROWS];
	tag_t       t_rd0    [MAX_ROWS];
	xlen_t      t_op     [MAX_ROWS];
	csr_addr_t  t_addr   [MAX_ROWS];
	logic       t_retire [MAX_ROWS];
	xlen_t      t_res    [MAX_ROWS];
	logic       t_ill    [MAX_ROWS];
	int         n_rows;

	// reference copies of the registers, updated while the table is built
	xlen_t m_mscratch;
	xlen_t m_mepc;
	xlen_t m_mstatus;
	xlen_t m_mie;
	xlen_t m_mip;
	xlen_t m_mtval;
	xlen_t m_mcycle;
	xlen_t m_minstret;

	logic [31:0] lcg_state;
	bit          drained;
	int          total_errors;

	csr_exec #(
		.RNBIT   (RNBIT),
		.HART_ID (HART)
	) uut (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.exe_valid  (exe_valid),
		.exe_rw     (exe_rw),
		.exe_rs     (exe_rs),
		.exe_rc     (exe_rc),
		.exe_rd0    (exe_rd0),
		.exe_op     (exe_op),
		.exe_addr   (exe_addr),
		.retire     (retire),
		.wb_valid   (wb_valid),
		.wb_res     (wb_res),
		.wb_rd0     (wb_rd0),
		.wb_illegal (wb_illegal)
	);

	csr_checker #(
		.RNBIT (RNBIT)
	) chk (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.wb_valid   (wb_valid),
		.wb_res     (wb_res),
		.wb_rd0     (wb_rd0),
		.wb_illegal (wb_illegal)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic xlen_t rand64();
		return {lcg_next(), lcg_next()};
	endfunction

	// csrrw, csrrs and csrrc as the ISA defines them, then the write mask
	function automatic xlen_t apply_rule(input int kind, input xlen_t old, input xlen_t op,
			input xlen_t mask);
		xlen_t v;
		case (kind)
			RW:      v = op;
			RS:      v = old | op;
			default: v = old & ~op;
		endcase
		return (old & ~mask) | (v & mask);
	endfunction

	task automatic add_row(input logic valid, input int kind, input logic to_x0,
			input xlen_t op, input csr_addr_t addr, input logic ret,
			input xlen_t res, input logic ill);
		t_valid[n_rows]  = valid;
		t_kind[n_rows]   = kind;
		t_rd0[n_rows]    = to_x0 ? '0 : tag_t'(n_rows + 1);
		t_op[n_rows]     = op;
		t_addr[n_rows]   = addr;
		t_retire[n_rows] = ret;
		t_res[n_rows]    = res;
		t_ill[n_rows]    = ill;
		n_rows++;
	endtask

	// a cycle with no request, optionally carrying a retire pulse
	task automatic idle_row(input logic ret);
		if (ret) begin
			m_minstret = m_minstret + 1;
		end
		add_row(1'b0, RW, 1'b1, '0, '0, ret, '0, 1'b0);
	endtask

	// the old value comes back unless csrrw targets x0
	task automatic csr_access(input int kind, input logic to_x0, input xlen_t op,
			input csr_addr_t addr, inout xlen_t model, input xlen_t mask);
		xlen_t res;
		res = (kind == RW && to_x0) ? '0 : model;
		add_row(1'b1, kind, to_x0, op, addr, 1'b0, res, 1'b0);
		model = apply_rule(kind, model, op, mask);
	endtask

	task automatic fixed_read(input csr_addr_t addr, input xlen_t value);
		add_row(1'b1, RS, 1'b0, '0, addr, 1'b0, value, 1'b0);
	endtask

	task automatic build_table();
		// back-to-back accesses on mscratch and mepc, bit 0 of mepc never sticks
		csr_access(RW, 1'b0, rand64(), CSR_MSCRATCH, m_mscratch, FULL_WMASK);
		csr_access(RS, 1'b0, rand64(), CSR_MSCRATCH, m_mscratch, FULL_WMASK);
		csr_access(RC, 1'b0, rand64(), CSR_MSCRATCH, m_mscratch, FULL_WMASK);
		csr_access(RS, 1'b0, '0, CSR_MSCRATCH, m_mscratch, FULL_WMASK);
		csr_access(RW, 1'b0, rand64() | 64'h1, CSR_MEPC, m_mepc, MEPC_WMASK);
		csr_access(RS, 1'b0, 64'h1, CSR_MEPC, m_mepc, MEPC_WMASK);
		csr_access(RC, 1'b0, rand64(), CSR_MEPC, m_mepc, MEPC_WMASK);
		csr_access(RS, 1'b0, '0, CSR_MEPC, m_mepc, MEPC_WMASK);
		// mstatus, mie and mip keep only their writable fields
		csr_access(RW, 1'b0, '1, CSR_MSTATUS, m_mstatus, MSTATUS_WMASK);
		csr_access(RC, 1'b0, 64'h8, CSR_MSTATUS, m_mstatus, MSTATUS_WMASK);
		csr_access(RS, 1'b0, '0, CSR_MSTATUS, m_mstatus, MSTATUS_WMASK);
		csr_access(RC, 1'b0, '0, CSR_MSTATUS, m_mstatus, MSTATUS_WMASK);
		csr_access(RS, 1'b0, '0, CSR_MSTATUS, m_mstatus, MSTATUS_WMASK);
		csr_access(RW, 1'b0, rand64(), CSR_MIE, m_mie, MIE_WMASK);
		csr_access(RS, 1'b0, '0, CSR_MIE, m_mie, MIE_WMASK);
		csr_access(RS, 1'b0, '1, CSR_MIP, m_mip, MIP_WMASK);
		csr_access(RC, 1'b0, 64'h80, CSR_MIP, m_mip, MIP_WMASK);
		csr_access(RS, 1'b0, '0, CSR_MIP, m_mip, MIP_WMASK);
		// machine information registers and misa
		fixed_read(CSR_MVENDORID, MVENDORID_VALUE);
		fixed_read(CSR_MARCHID, MARCHID_VALUE);
		fixed_read(CSR_MIMPID, MIMPID_VALUE);
		fixed_read(CSR_MHARTID, HART);
		fixed_read(CSR_MISA, MISA_VALUE);
		add_row(1'b1, RW, 1'b0, rand64(), CSR_MISA, 1'b0, MISA_VALUE, 1'b0);
		add_row(1'b1, RW, 1'b0, rand64(), CSR_MHARTID, 1'b0, '0, 1'b1);
		add_row(1'b1, RS, 1'b0, 64'h3, CSR_MVENDORID, 1'b0, '0, 1'b1);
		// nobody owns 7c0
		add_row(1'b1, RS, 1'b0, '0, 12'h7C0, 1'b0, '0, 1'b1);
		csr_access(RW, 1'b1, rand64(), CSR_MTVAL, m_mtval, FULL_WMASK);
		csr_access(RS, 1'b0, '0, CSR_MTVAL, m_mtval, FULL_WMASK);
		// one idle edge after the write adds a single increment
		csr_access(RW, 1'b1, rand64(), CSR_MCYCLE, m_mcycle, FULL_WMASK);
		idle_row(1'b0);
		m_mcycle = m_mcycle + 1;
		csr_access(RS, 1'b0, '0, CSR_MCYCLE, m_mcycle, FULL_WMASK);
		// minstret sees only the pulses in this table
		csr_access(RS, 1'b0, '0, CSR_MINSTRET, m_minstret, FULL_WMASK);
		idle_row(1'b1);
		idle_row(1'b0);
		idle_row(1'b1);
		idle_row(1'b1);
		csr_access(RS, 1'b0, '0, CSR_MINSTRET, m_minstret, FULL_WMASK);
		// the write wins over the retire pulse on the same edge
		csr_access(RW, 1'b1, rand64(), CSR_MINSTRET, m_minstret, FULL_WMASK);
		t_retire[n_rows-1] = 1'b1;
		idle_row(1'b1);
		csr_access(RS, 1'b0, '0, CSR_MINSTRET, m_minstret, FULL_WMASK);
	endtask

	initial begin
		rst_n      = 1'b0;
		exe_valid  = 1'b0;
		exe_rw     = 1'b0;
		exe_rs     = 1'b0;
		exe_rc     = 1'b0;
		exe_rd0    = '0;
		exe_op     = '0;
		exe_addr   = '0;
		retire     = 1'b0;
		lcg_state  = 32'h239b;
		n_rows     = 0;
		m_mscratch = '0;
		m_mepc     = '0;
		m_mstatus  = '0;
		m_mie      = '0;
		m_mip      = '0;
		m_mtval    = '0;
		m_mcycle   = '0;
		m_minstret = '0;
		build_table();
		repeat (16) @(posedge CLK);
		#1 rst_n = 1'b1;
		for (int i = 0; i < n_rows; i++) begin
			@(posedge CLK);
			#1;
			exe_valid = t_valid[i];
			exe_rw    = (t_kind[i] == RW);
			exe_rs    = (t_kind[i] == RS);
			exe_rc    = (t_kind[i] == RC);
			exe_rd0   = t_rd0[i];
			exe_op    = t_op[i];
			exe_addr  = t_addr[i];
			retire    = t_retire[i];
			if (t_valid[i]) begin
				chk.push_expected(i, t_res[i], t_rd0[i], t_ill[i]);
			end
		end
		@(posedge CLK);
		#1;
		exe_valid = 1'b0;
		retire    = 1'b0;
		chk.wait_drained(20, drained);
		total_errors = chk.errors + uut.u_writeback.u_assert.fail_count;
		if (!drained) begin
			total_errors++;
		end
		$display("%0d tests checked, %0d passed, %0d errors", chk.checked, chk.passed,
			total_errors);
		if (total_errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
rtl/core_pkg.sv
rtl/csr_pkg.sv
rtl/csr_trap_regs.sv
rtl/csr_counter_regs.sv
rtl/csr_writeback.sv
rtl/csr_exec.sv
testbench/csr_exec_assertions.sv
testbench/csr_checker.sv
testbench/tb_csr_exec.sv
